// File: i2c_defs.svh
// I2C master widths and quarter-bit clock counts for each bus speed
`ifndef I2C_DEFS_SVH
`define I2C_DEFS_SVH

// Device address and byte widths
`define I2C_ADDR_W 7
`define I2C_BYTE_W 8

// System clocks per quarter SCL period, for a 10 MHz clock
// Standard gives 100 kHz
`define I2C_Q_STD 25

// Fast and fast-plus
`define I2C_Q_FAST 6
`define I2C_Q_FPLUS 3

// Quarter counter must hold the standard count
`define I2C_QCNT_W 5

`endif

// File: i2c_pkg.sv
// Shared types for the I2C master: bus speed, bit commands and sequencer phases
package i2c_pkg;

   // Bus speed chosen at run time
   typedef enum logic [1:0] {
      SPEED_STD,
      SPEED_FAST,
      SPEED_FPLUS
   } i2c_speed_t;

   // Commands from the byte sequencer to the bit engine
   typedef enum logic [1:0] {
      CMD_START,
      CMD_STOP,
      CMD_WRITE,
      CMD_READ
   } bit_cmd_t;

   // Transaction phases, ACKn follows the byte it acknowledges
   typedef enum logic [3:0] {
      IDLE, START,
      DEV_W, ACK1,
      REG, ACK2,
      WDATA, ACK3,
      RESTART,
      DEV_R, ACK4,
      RDATA, MNACK,
      STOP
   } seq_state_t;

endpackage

// File: i2c_bit_if.sv
// Command link between the I2C byte sequencer and the bit engine
`timescale 1ns/1ps

interface bit_if;

   // Command and the bit to send with a write
   i2c_pkg::bit_cmd_t cmd;
   logic              tx_bit;

   // One-cycle pulse, only while no command is pending
   logic              cmd_valid;

   // One-cycle pulse at the end of the fourth quarter
   logic              bit_done;

   // Sampled data, valid with bit_done
   logic              rx_bit;

   modport seq (
      output cmd, tx_bit, cmd_valid,
      input  bit_done, rx_bit
   );

   modport eng (
      input  cmd, tx_bit, cmd_valid,
      output bit_done, rx_bit
   );

endinterface

// File: i2c_quarter_timer.sv
// Quarter-bit tick generator for the I2C bit engine, speed set at run time
`timescale 1ns/1ps
`include "i2c_defs.svh"

module i2c_quarter_timer
(
   input  logic                sda,
   input  logic                rst_n,
   input  i2c_pkg::i2c_speed_t speed,
   input  logic                run,
   output logic                quarter_tick
);

   logic [`I2C_QCNT_W-1:0] speed_len;
   logic [`I2C_QCNT_W-1:0] q_len;
   logic [`I2C_QCNT_W-1:0] cnt;
   logic                   run_q;

   always_comb
   begin
      case (speed)
         i2c_pkg::SPEED_FAST:  speed_len = `I2C_QCNT_W'(`I2C_Q_FAST);
         i2c_pkg::SPEED_FPLUS: speed_len = `I2C_QCNT_W'(`I2C_Q_FPLUS);
         default:              speed_len = `I2C_QCNT_W'(`I2C_Q_STD);
      endcase
   end

   // No tick in the cycle run rises, the count is loaded then
   assign quarter_tick = run_q && (cnt == '0);

   always_ff @(posedge sda)
   begin
      if (!rst_n)
      begin
         run_q <= 1'b0;
         q_len <= '0;
         cnt   <= '0;
      end
      else
      begin
         run_q <= run;
         if (run && !run_q)
         begin
            // Speed held for the whole command
            q_len <= speed_len;
            cnt   <= speed_len - 1'b1;
         end
         else if (run)
         begin
            cnt <= (cnt == '0) ? q_len - 1'b1 : cnt - 1'b1;
         end
      end
   end

   // Reload on the last tick keeps the count off zero once run drops
   a_no_tick_idle: assert property (@(posedge sda) disable iff (!rst_n)
      !run |-> !quarter_tick);

endmodule

// File: i2c_bit_engine.sv
// I2C bit engine: START, STOP, write and read bits in four quarters on an open-drain bus
`timescale 1ns/1ps

module i2c_bit_engine
(
   input  logic   sda,
   input  logic   rst_n,
   bit_if.eng     bus,
   input  logic   quarter_tick,
   output logic   run,
   input  logic   scl_in,
   input  logic   data_in,
   output logic   scl_drive_low,
   output logic   data_drive_low
);

   logic              busy;
   i2c_pkg::bit_cmd_t cmd_r;
   logic [1:0]        phase;
   logic              rx_r;
   logic [1:0]        scl_sync;
   logic [1:0]        data_sync;
   logic              start_cmd;
   logic              step;
   i2c_pkg::bit_cmd_t nxt_cmd;
   logic [1:0]        nxt_phase;
   logic              scl_nxt;
   logic              data_nxt;

   // Commands arriving while busy are dropped
   assign start_cmd = bus.cmd_valid && !busy;
   assign step      = busy && quarter_tick && (phase != 2'd3);
   assign nxt_cmd   = start_cmd ? bus.cmd : cmd_r;
   assign nxt_phase = start_cmd ? 2'd0 : phase + 2'd1;

   // Drive levels for the quarter about to begin, 1 pulls the line low
   always_comb
   begin
      scl_nxt  = scl_drive_low;
      data_nxt = data_drive_low;
      case (nxt_cmd)
         i2c_pkg::CMD_START:
         begin
            // SCL left as is in the first quarter, low after a byte
            case (nxt_phase)
               2'd0:    data_nxt = 1'b0;
               2'd1:    scl_nxt = 1'b0;
               2'd2:    data_nxt = 1'b1;
               default: scl_nxt = 1'b1;
            endcase
         end
         i2c_pkg::CMD_STOP:
         begin
            if (nxt_phase == 2'd0)
            begin
               scl_nxt  = 1'b1;
               data_nxt = 1'b1;
            end
            else if (nxt_phase == 2'd1)
               scl_nxt = 1'b0;
            else if (nxt_phase == 2'd2)
               data_nxt = 1'b0;
         end
         default:
         begin
            // Write and read share the SCL pattern low, high, high, low
            if (nxt_phase == 2'd0)
            begin
               scl_nxt  = 1'b1;
               data_nxt = (nxt_cmd == i2c_pkg::CMD_WRITE) && !bus.tx_bit;
            end
            else if (nxt_phase == 2'd1)
               scl_nxt = 1'b0;
            else if (nxt_phase == 2'd3)
               scl_nxt = 1'b1;
         end
      endcase
   end

   always_ff @(posedge sda)
   begin
      if (!rst_n)
      begin
         busy           <= 1'b0;
         cmd_r          <= i2c_pkg::CMD_STOP;
         phase          <= 2'd0;
         scl_drive_low  <= 1'b0;
         data_drive_low <= 1'b0;
         scl_sync       <= 2'b11;
         data_sync      <= 2'b11;
      end
      else
      begin
         scl_sync  <= {scl_sync[0], scl_in};
         data_sync <= {data_sync[0], data_in};
         if (start_cmd)
         begin
            busy  <= 1'b1;
            cmd_r <= bus.cmd;
            phase <= 2'd0;
         end
         else if (busy && quarter_tick)
         begin
            phase <= phase + 2'd1;
            if (phase == 2'd3)
               busy <= 1'b0;
         end
         if (start_cmd || step)
         begin
            scl_drive_low  <= scl_nxt;
            data_drive_low <= data_nxt;
         end
      end
   end

   // Sample at the third tick, SCL high for a full quarter by then
   always_ff @(posedge sda)
   begin
      if (busy && quarter_tick && (phase == 2'd2))
         rx_r <= data_sync[1];
   end

   assign run          = busy;
   assign bus.bit_done = busy && quarter_tick && (phase == 2'd3);
   assign bus.rx_bit   = rx_r;

   a_data_edge_scl_high: assert property (@(posedge sda) disable iff (!rst_n)
      (!scl_drive_low && !$past(scl_drive_low) && (data_drive_low != $past(data_drive_low)))
      |-> (cmd_r inside {i2c_pkg::CMD_START, i2c_pkg::CMD_STOP}));

   a_bit_done_pulse: assert property (@(posedge sda) disable iff (!rst_n)
      bus.bit_done |=> !bus.bit_done);

   // No slave stretches SCL, so the bus shows it high at the sample point
   a_scl_seen_high: assert property (@(posedge sda) disable iff (!rst_n)
      (busy && quarter_tick && (phase == 2'd2)) |-> scl_sync[1]);

endmodule

// File: i2c_byte_sequencer.sv
// I2C register transaction FSM: serializes address and data bytes and checks slave ACKs
`timescale 1ns/1ps
`include "i2c_defs.svh"

module i2c_byte_sequencer
(
   input  logic                   sda,
   input  logic                   rst_n,
   input  logic                   req,
   input  logic                   rw,
   input  logic [`I2C_ADDR_W-1:0] dev_addr,
   input  logic [`I2C_BYTE_W-1:0] reg_addr,
   input  logic [`I2C_BYTE_W-1:0] wdata,
   output logic                   busy,
   output logic                   done,
   output logic [`I2C_BYTE_W-1:0] rdata,
   output logic                   ack_error,
   bit_if.seq                     bus
);

   i2c_pkg::seq_state_t    state;
   i2c_pkg::seq_state_t    ack_state;
   logic                   pending;
   logic                   issue;
   logic                   cmd_valid_r;
   i2c_pkg::bit_cmd_t      cmd_sel;
   i2c_pkg::bit_cmd_t      cmd_r;
   logic                   tx_sel;
   logic                   tx_r;
   logic [2:0]             bit_cnt;
   logic                   byte_last;
   logic [`I2C_BYTE_W-1:0] shift_r;
   logic                   rw_r;
   logic [`I2C_ADDR_W-1:0] dev_r;
   logic [`I2C_BYTE_W-1:0] reg_r;
   logic [`I2C_BYTE_W-1:0] wdata_r;

   // One command in flight, the next goes out after bit_done
   assign issue     = busy && !pending;
   assign byte_last = (bit_cnt == 3'd7);

   always_comb
   begin
      cmd_sel = i2c_pkg::CMD_READ;
      tx_sel  = shift_r[`I2C_BYTE_W-1];
      case (state)
         i2c_pkg::START, i2c_pkg::RESTART: cmd_sel = i2c_pkg::CMD_START;
         i2c_pkg::DEV_W, i2c_pkg::REG,
         i2c_pkg::WDATA, i2c_pkg::DEV_R:   cmd_sel = i2c_pkg::CMD_WRITE;
         i2c_pkg::MNACK:
         begin
            // NACK ends the read after one byte
            cmd_sel = i2c_pkg::CMD_WRITE;
            tx_sel  = 1'b1;
         end
         i2c_pkg::STOP:                    cmd_sel = i2c_pkg::CMD_STOP;
         default:                          cmd_sel = i2c_pkg::CMD_READ;
      endcase
      case (state)
         i2c_pkg::DEV_W: ack_state = i2c_pkg::ACK1;
         i2c_pkg::REG:   ack_state = i2c_pkg::ACK2;
         i2c_pkg::WDATA: ack_state = i2c_pkg::ACK3;
         default:        ack_state = i2c_pkg::ACK4;
      endcase
   end

   always_ff @(posedge sda)
   begin
      if (!rst_n)
      begin
         state       <= i2c_pkg::IDLE;
         busy        <= 1'b0;
         done        <= 1'b0;
         ack_error   <= 1'b0;
         pending     <= 1'b0;
         cmd_valid_r <= 1'b0;
         bit_cnt     <= 3'd0;
         shift_r     <= '0;
         rdata       <= '0;
      end
      else
      begin
         done        <= 1'b0;
         cmd_valid_r <= issue;
         if (issue)
            pending <= 1'b1;
         else if (bus.bit_done)
            pending <= 1'b0;
         if (req && !busy)
         begin
            busy      <= 1'b1;
            ack_error <= 1'b0;
            state     <= i2c_pkg::START;
         end
         else if (busy && bus.bit_done)
         begin
            case (state)
               i2c_pkg::START:
               begin
                  state   <= i2c_pkg::DEV_W;
                  shift_r <= {dev_r, 1'b0};
                  bit_cnt <= 3'd0;
               end
               i2c_pkg::RESTART:
               begin
                  state   <= i2c_pkg::DEV_R;
                  shift_r <= {dev_r, 1'b1};
                  bit_cnt <= 3'd0;
               end
               i2c_pkg::DEV_W, i2c_pkg::REG, i2c_pkg::WDATA, i2c_pkg::DEV_R:
               begin
                  // MSB first, the counter wraps back to zero
                  shift_r <= {shift_r[`I2C_BYTE_W-2:0], 1'b0};
                  bit_cnt <= bit_cnt + 3'd1;
                  if (byte_last)
                     state <= ack_state;
               end
               i2c_pkg::ACK1, i2c_pkg::ACK2, i2c_pkg::ACK3, i2c_pkg::ACK4:
               begin
                  state <= i2c_pkg::STOP;
                  if (bus.rx_bit)
                     ack_error <= 1'b1;
                  else if (state == i2c_pkg::ACK1)
                  begin
                     state   <= i2c_pkg::REG;
                     shift_r <= reg_r;
                  end
                  else if (state == i2c_pkg::ACK2)
                  begin
                     if (rw_r)
                        state <= i2c_pkg::RESTART;
                     else
                        state <= i2c_pkg::WDATA;
                     shift_r <= wdata_r;
                  end
                  else if (state == i2c_pkg::ACK4)
                     state <= i2c_pkg::RDATA;
               end
               i2c_pkg::RDATA:
               begin
                  shift_r <= {shift_r[`I2C_BYTE_W-2:0], bus.rx_bit};
                  bit_cnt <= bit_cnt + 3'd1;
                  if (byte_last)
                  begin
                     rdata <= {shift_r[`I2C_BYTE_W-2:0], bus.rx_bit};
                     state <= i2c_pkg::MNACK;
                  end
               end
               i2c_pkg::MNACK: state <= i2c_pkg::STOP;
               default:
               begin
                  state <= i2c_pkg::IDLE;
                  busy  <= 1'b0;
                  done  <= 1'b1;
               end
            endcase
         end
      end
   end

   // Request fields and the command on the link
   always_ff @(posedge sda)
   begin
      if (req && !busy)
      begin
         rw_r    <= rw;
         dev_r   <= dev_addr;
         reg_r   <= reg_addr;
         wdata_r <= wdata;
      end
      if (issue)
      begin
         cmd_r <= cmd_sel;
         tx_r  <= tx_sel;
      end
   end

   assign bus.cmd_valid = cmd_valid_r;
   assign bus.cmd       = cmd_r;
   assign bus.tx_bit    = tx_r;

   a_one_cmd_in_flight: assert property (@(posedge sda) disable iff (!rst_n)
      bus.cmd_valid |=> (!bus.cmd_valid until bus.bit_done));

   a_done_after_stop: assert property (@(posedge sda) disable iff (!rst_n)
      done |-> ($past(state) == i2c_pkg::STOP));

endmodule

// File: i2c_master_top.sv
// I2C master for single-byte register writes and reads on an open-drain bus
`timescale 1ns/1ps
`include "i2c_defs.svh"

module i2c_master_top
(
   input  logic                   sda,
   input  logic                   rst_n,
   input  i2c_pkg::i2c_speed_t    speed,
   input  logic                   req,
   input  logic                   rw,
   input  logic [`I2C_ADDR_W-1:0] dev_addr,
   input  logic [`I2C_BYTE_W-1:0] reg_addr,
   input  logic [`I2C_BYTE_W-1:0] wdata,
   output logic                   busy,
   output logic                   done,
   output logic [`I2C_BYTE_W-1:0] rdata,
   output logic                   ack_error,
   input  logic                   scl_in,
   input  logic                   data_in,
   output logic                   scl_drive_low,
   output logic                   data_drive_low
);

   logic quarter_tick;
   logic run;

   bit_if u_bit_if ();

   // Ticks only while the engine runs a command
   i2c_quarter_timer u_i2c_quarter_timer (
      .sda          (sda),
      .rst_n        (rst_n),
      .speed        (speed),
      .run          (run),
      .quarter_tick (quarter_tick)
   );

   i2c_byte_sequencer u_i2c_byte_sequencer (
      .sda       (sda),
      .rst_n     (rst_n),
      .req       (req),
      .rw        (rw),
      .dev_addr  (dev_addr),
      .reg_addr  (reg_addr),
      .wdata     (wdata),
      .busy      (busy),
      .done      (done),
      .rdata     (rdata),
      .ack_error (ack_error),
      .bus       (u_bit_if.seq)
   );

   i2c_bit_engine u_i2c_bit_engine (
      .sda            (sda),
      .rst_n          (rst_n),
      .bus            (u_bit_if.eng),
      .quarter_tick   (quarter_tick),
      .run            (run),
      .scl_in         (scl_in),
      .data_in        (data_in),
      .scl_drive_low  (scl_drive_low),
      .data_drive_low (data_drive_low)
   );

endmodule

// File: tb_i2c_slave.sv
// Behavioural I2C register slave on the open-drain bus, for simulation only
`timescale 1ns/1ps

module tb_i2c_slave
#(
   parameter logic [6:0] slave_addr = 7'h5A
)
(
   input  logic sda,
   input  logic rst_n,
   input  logic scl,
   input  logic data,
   output logic data_pull_low
);

   typedef enum int {st_idle, st_rx, st_ack, st_tx, st_master_ack} slave_state_t;

   slave_state_t st;
   logic [7:0]   regs [0:255];
   logic [7:0]   shift;
   logic [7:0]   reg_ptr;
   logic [3:0]   bit_cnt;
   logic [1:0]   byte_idx;
   logic         reading;
   logic         scl_q;
   logic         data_q;
   integer       idx;

   always @(posedge sda)
   begin
      scl_q  <= scl;
      data_q <= data;
      if (!rst_n)
      begin
         for (idx = 0; idx < 256; idx = idx + 1)
            regs[idx] <= 8'(idx) ^ 8'hA5;
         st            <= st_idle;
         data_pull_low <= 1'b0;
         shift         <= 8'h00;
         reg_ptr       <= 8'h00;
         bit_cnt       <= 4'd0;
         byte_idx      <= 2'd0;
         reading       <= 1'b0;
      end
      else if (scl && scl_q && data_q && !data)
      begin
         // START or repeated START, address byte comes next
         st            <= st_rx;
         bit_cnt       <= 4'd0;
         byte_idx      <= 2'd0;
         data_pull_low <= 1'b0;
      end
      else if (scl && scl_q && !data_q && data)
      begin
         st            <= st_idle;
         data_pull_low <= 1'b0;
      end
      else if (scl && !scl_q)
      begin
         if (st == st_rx)
         begin
            shift   <= {shift[6:0], data};
            bit_cnt <= bit_cnt + 4'd1;
         end
      end
      else if (!scl && scl_q)
      begin
         // Data only changes while SCL is low
         case (st)
            st_rx:
            begin
               if (bit_cnt == 4'd8)
               begin
                  bit_cnt <= 4'd0;
                  if (byte_idx != 2'd2)
                     byte_idx <= byte_idx + 2'd1;
                  if (byte_idx == 2'd0)
                  begin
                     reading <= shift[0];
                     if (shift[7:1] == slave_addr)
                     begin
                        st            <= st_ack;
                        data_pull_low <= 1'b1;
                     end
                     else
                        st <= st_idle;
                  end
                  else
                  begin
                     if (byte_idx == 2'd1)
                        reg_ptr <= shift;
                     else
                     begin
                        regs[reg_ptr] <= shift;
                        reg_ptr       <= reg_ptr + 8'd1;
                     end
                     st            <= st_ack;
                     data_pull_low <= 1'b1;
                  end
               end
            end
            st_ack:
            begin
               if (reading)
               begin
                  // First read bit goes out right after the ACK clock
                  st            <= st_tx;
                  shift         <= regs[reg_ptr];
                  data_pull_low <= !regs[reg_ptr][7];
                  bit_cnt       <= 4'd1;
               end
               else
               begin
                  st            <= st_rx;
                  data_pull_low <= 1'b0;
               end
            end
            st_tx:
            begin
               if (bit_cnt == 4'd8)
               begin
                  st            <= st_master_ack;
                  data_pull_low <= 1'b0;
               end
               else
               begin
                  data_pull_low <= !shift[6];
                  shift         <= {shift[6:0], 1'b0};
                  bit_cnt       <= bit_cnt + 4'd1;
               end
            end
            st_master_ack:
               st <= st_idle;
            default:
               data_pull_low <= 1'b0;
         endcase
      end
   end

endmodule

// File: tb_i2c_master.sv
// Testbench for the I2C master with register writes and reads against a model slave
`timescale 1ns/1ps
`include "i2c_defs.svh"

module tb_i2c_master;

   localparam int         max_rows      = 16;
   localparam int         done_timeout  = 20000;
   localparam int         quiet_cycles  = 500;
   localparam int         handoff_slack = 8;
   localparam logic [6:0] slave_dev     = 7'h5A;
   localparam logic [6:0] other_dev     = 7'h3C;

   logic                   sda;
   logic                   rst_n;
   i2c_pkg::i2c_speed_t    speed;
   logic                   req;
   logic                   rw;
   logic [`I2C_ADDR_W-1:0] dev_addr;
   logic [`I2C_BYTE_W-1:0] reg_addr;
   logic [`I2C_BYTE_W-1:0] wdata;
   logic                   busy;
   logic                   done;
   logic [`I2C_BYTE_W-1:0] rdata;
   logic                   ack_error;
   logic                   scl_drive_low;
   logic                   data_drive_low;
   logic                   slave_pull_low;
   wire                    scl_line;
   wire                    data_line;

   // Stimulus table with one transaction per row
   i2c_pkg::i2c_speed_t    row_speed     [0:max_rows-1];
   logic                   row_rw        [0:max_rows-1];
   logic [`I2C_ADDR_W-1:0] row_dev       [0:max_rows-1];
   logic [`I2C_BYTE_W-1:0] row_reg       [0:max_rows-1];
   logic [`I2C_BYTE_W-1:0] row_data      [0:max_rows-1];
   logic                   row_exp_err   [0:max_rows-1];
   logic [`I2C_BYTE_W-1:0] row_exp_rdata [0:max_rows-1];
   logic                   row_second    [0:max_rows-1];
   int                     row_count;
   int                     row_idx;

   // Register contents the slave should hold
   logic [`I2C_BYTE_W-1:0] ref_regs [0:255];
   integer                 seed;

   // Open-drain bus as a wired-AND of all drivers
   assign scl_line  = !scl_drive_low;
   assign data_line = !(data_drive_low || slave_pull_low);

   i2c_master_top u_i2c_master_top (
      .sda            (sda),
      .rst_n          (rst_n),
      .speed          (speed),
      .req            (req),
      .rw             (rw),
      .dev_addr       (dev_addr),
      .reg_addr       (reg_addr),
      .wdata          (wdata),
      .busy           (busy),
      .done           (done),
      .rdata          (rdata),
      .ack_error      (ack_error),
      .scl_in         (scl_line),
      .data_in        (data_line),
      .scl_drive_low  (scl_drive_low),
      .data_drive_low (data_drive_low)
   );

   tb_i2c_slave #(.slave_addr(slave_dev)) u_tb_i2c_slave (
      .sda           (sda),
      .rst_n         (rst_n),
      .scl           (scl_line),
      .data          (data_line),
      .data_pull_low (slave_pull_low)
   );

   initial
   begin
      sda = 1'b0;
      forever #50 sda = ~sda;
   end

   task fail_run(input string why);
      $display("%s", why);
      $display("Result: FAILED");
      $fatal(1, "Simulation stopped after a failure");
   endtask

   task check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("** Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
         fail_run("Stopping at the first mismatch");
      end
   endtask

   function automatic logic [7:0] reg_reset_value(input logic [7:0] addr);
      return addr ^ 8'hA5;
   endfunction

   // Clocks per quarter bit at each bus speed
   function automatic int quarter_clocks(input i2c_pkg::i2c_speed_t spd);
      case (spd)
         i2c_pkg::SPEED_FAST:  return `I2C_Q_FAST;
         i2c_pkg::SPEED_FPLUS: return `I2C_Q_FPLUS;
         default:              return `I2C_Q_STD;
      endcase
   endfunction

   // Bit commands in one transaction, a byte with its ACK counts nine
   function automatic int bit_commands(input logic rd, input logic nack);
      if (nack)
         return 1 + 9 + 1;
      else if (!rd)
         return 1 + 9 + 9 + 9 + 1;
      else
         return 1 + 9 + 9 + 1 + 9 + 9 + 1;
   endfunction

   // Expected values follow the slave register rule and writes land only when acked
   task add_row(input i2c_pkg::i2c_speed_t spd, input logic rd, input logic [6:0] dev,
                input logic [7:0] addr, input logic second);
      logic [7:0] data;
      logic       acked;
      data  = 8'($random(seed));
      acked = (dev == slave_dev);
      row_speed[row_count]     = spd;
      row_rw[row_count]        = rd;
      row_dev[row_count]       = dev;
      row_reg[row_count]       = addr;
      row_data[row_count]      = data;
      row_exp_err[row_count]   = !acked;
      row_exp_rdata[row_count] = ref_regs[addr];
      row_second[row_count]    = second;
      if (!rd && acked)
         ref_regs[addr] = data;
      row_count++;
   endtask

   task build_table;
      int i;
      for (i = 0; i < 256; i++)
         ref_regs[i] = reg_reset_value(8'(i));
      // Never-written registers
      add_row(i2c_pkg::SPEED_STD,   1'b1, slave_dev, 8'h10, 1'b0);
      add_row(i2c_pkg::SPEED_FPLUS, 1'b1, slave_dev, 8'hFF, 1'b0);
      // Write and read back at each speed
      add_row(i2c_pkg::SPEED_STD,   1'b0, slave_dev, 8'h21, 1'b0);
      add_row(i2c_pkg::SPEED_STD,   1'b1, slave_dev, 8'h21, 1'b0);
      add_row(i2c_pkg::SPEED_FAST,  1'b0, slave_dev, 8'h42, 1'b0);
      add_row(i2c_pkg::SPEED_FAST,  1'b1, slave_dev, 8'h42, 1'b0);
      add_row(i2c_pkg::SPEED_FPLUS, 1'b0, slave_dev, 8'h83, 1'b0);
      add_row(i2c_pkg::SPEED_FPLUS, 1'b1, slave_dev, 8'h83, 1'b0);
      // No device answers at this address
      add_row(i2c_pkg::SPEED_FAST,  1'b0, other_dev, 8'h21, 1'b0);
      add_row(i2c_pkg::SPEED_STD,   1'b1, other_dev, 8'h42, 1'b0);
      add_row(i2c_pkg::SPEED_FAST,  1'b1, slave_dev, 8'h21, 1'b0);
      add_row(i2c_pkg::SPEED_FPLUS, 1'b0, other_dev, 8'h77, 1'b0);
      add_row(i2c_pkg::SPEED_FPLUS, 1'b1, slave_dev, 8'h77, 1'b0);
      // Second req during the transfer must be dropped
      add_row(i2c_pkg::SPEED_FAST,  1'b0, slave_dev, 8'h60, 1'b1);
      add_row(i2c_pkg::SPEED_FAST,  1'b1, slave_dev, 8'h60, 1'b0);
   endtask

   task check_idle(input string when);
      check_value({when, " busy"}, busy, 1'b0);
      check_value({when, " done"}, done, 1'b0);
      check_value({when, " ack_error"}, ack_error, 1'b0);
      check_value({when, " scl_drive_low"}, scl_drive_low, 1'b0);
      check_value({when, " data_drive_low"}, data_drive_low, 1'b0);
   endtask

   task wait_done(output int cycles);
      cycles = 0;
      while (!done && cycles < done_timeout)
      begin
         @(negedge sda);
         cycles++;
      end
      if (!done)
         fail_run("Timeout: the DUT never pulsed done");
   endtask

   task apply_row(input int i);
      int    extra_done;
      int    cycles;
      int    cmds;
      int    lo;
      int    hi;
      string tag;
      tag      = $sformatf("row %0d", i);
      speed    = row_speed[i];
      rw       = row_rw[i];
      dev_addr = row_dev[i];
      reg_addr = row_reg[i];
      wdata    = row_data[i];
      req      = 1'b1;
      @(negedge sda);
      req = 1'b0;
      check_value({tag, " busy after req"}, busy, 1'b1);
      if (row_second[i])
      begin
         repeat (3) @(negedge sda);
         check_value({tag, " busy before second req"}, busy, 1'b1);
         wdata = ~row_data[i];
         req   = 1'b1;
         @(negedge sda);
         req = 1'b0;
      end
      wait_done(cycles);
      check_value({tag, " ack_error"}, ack_error, row_exp_err[i]);
      check_value({tag, " busy at done"}, busy, 1'b0);
      check_value({tag, " scl released at done"}, scl_drive_low, 1'b0);
      check_value({tag, " data released at done"}, data_drive_low, 1'b0);
      if (row_rw[i] && !row_exp_err[i])
         check_value({tag, " rdata"}, rdata, row_exp_rdata[i]);
      // Four quarters per command at the row's speed, plus a short handoff
      cmds = bit_commands(row_rw[i], row_exp_err[i]);
      lo   = cmds * 4 * quarter_clocks(row_speed[i]);
      hi   = lo + cmds * handoff_slack;
      check_value({tag, " duration within bounds"}, (cycles >= lo) && (cycles <= hi), 1'b1);
      if (row_second[i])
      begin
         extra_done = 0;
         repeat (quiet_cycles)
         begin
            @(negedge sda);
            if (done || busy)
               extra_done++;
         end
         check_value({tag, " activity after done"}, extra_done, 0);
      end
      @(negedge sda);
   endtask

   initial
   begin
      seed      = 32'h9f5ab7ab;
      row_count = 0;
      rst_n     = 1'b0;
      speed     = i2c_pkg::SPEED_STD;
      req       = 1'b0;
      rw        = 1'b0;
      dev_addr  = '0;
      reg_addr  = '0;
      wdata     = '0;
      build_table();
      repeat (8) @(negedge sda);
      rst_n = 1'b1;
      repeat (4)
      begin
         @(negedge sda);
         check_idle("after reset");
      end
      for (row_idx = 0; row_idx < row_count; row_idx++)
         apply_row(row_idx);
      $display("Result: PASSED");
      $finish;
   end

endmodule

// File: build.f
+incdir+.
i2c_pkg.sv
i2c_bit_if.sv
i2c_quarter_timer.sv
i2c_bit_engine.sv
i2c_byte_sequencer.sv
i2c_master_top.sv
tb_i2c_slave.sv
tb_i2c_master.sv

// File: Bender.yml
package:
  name: i2c_master

export_include_dirs:
  - .

sources:
  - i2c_pkg.sv
  - i2c_bit_if.sv
  - i2c_quarter_timer.sv
  - i2c_bit_engine.sv
  - i2c_byte_sequencer.sv
  - i2c_master_top.sv
  - target: test
    files:
      - tb_i2c_slave.sv
      - tb_i2c_master.sv
